/* cred_ledger_top.f */
rtl/cred_cfg_pkg.sv
rtl/cred_op_pkg.sv
rtl/cred_rf_pg.sv
rtl/cred_req_fifo.sv
rtl/cred_arb.sv
rtl/cred_rmw_pipe.sv
rtl/cred_ledger_top.sv
tb/cred_ledger_checker.sv
tb/tb_cred_ledger.sv

/* tb/tb_cred_ledger.sv */
// ----------------------------------------------------------
// Testbench of the credit ledger. Drives reset, directed and
// random strobes and a power cycle; the checker compares.
// ----------------------------------------------------------
`default_nettype none

module tb_cred_ledger;

    import cred_cfg_pkg::*;
    import cred_op_pkg::*;

    localparam int N_RAND    = 400;
    localparam int N_FWD     = 32;
    localparam int N_SAT     = 515;
    localparam int N_OFF_ENQ = 6;
    localparam int N_OFF_DEQ = 7;
    localparam int N_PWR     = 1;
    localparam int N_STROBES = 2 + 2 * N_RAND + 2 * N_FWD + N_OFF_ENQ + N_OFF_DEQ + 2 * N_SAT;
    localparam int TIMEOUT   = N_STROBES * 8 + N_PWR * 64 + 200;
    localparam int FULL      = (1 << cred_width) - 1;

    logic       clk;
    logic       rst;
    logic       enq_v;
    cred_addr_t enq_addr;
    logic       deq_v;
    cred_addr_t deq_addr;
    logic       pwr_enable_b_in;
    logic       pgcb_isol_en;
    logic       pwr_enable_b_out;
    logic       upd_v;
    cred_upd_t  upd;
    logic       enq_ovf;
    logic       deq_ovf;
    logic       ready;

    int         chk_errs;
    int         enq_drops;
    int         deq_drops;
    int         sat_cnt;
    int         unf_cnt;
    logic       balanced;

    int         tb_errs;
    int         cycle_cnt;
    int         base_a;
    int         base_b;
    integer     seed = 32'h42f2_165f;
    logic [31:0] rnd;
    cred_addr_t ra;
    cred_addr_t rb;
    string      phase = "reset";

    cred_ledger_top u_dut (
         .clk(clk), .rst(rst), .enq_v(enq_v), .enq_addr(enq_addr), .deq_v(deq_v)
        ,.deq_addr(deq_addr), .pwr_enable_b_in(pwr_enable_b_in), .pgcb_isol_en(pgcb_isol_en)
        ,.pwr_enable_b_out(pwr_enable_b_out), .upd_v(upd_v), .upd(upd)
        ,.enq_ovf(enq_ovf), .deq_ovf(deq_ovf), .ready(ready)
    );

    cred_ledger_checker u_chk (
         .clk(clk), .rst(rst), .enq_v(enq_v), .deq_v(deq_v)
        ,.pwr_enable_b_in(pwr_enable_b_in), .pwr_enable_b_out(pwr_enable_b_out)
        ,.ready(ready), .upd_v(upd_v), .upd(upd), .enq_ovf(enq_ovf), .deq_ovf(deq_ovf)
        ,.err_cnt(chk_errs), .enq_drops(enq_drops), .deq_drops(deq_drops)
        ,.sat_cnt(sat_cnt), .unf_cnt(unf_cnt), .balanced(balanced)
    );

    always #5 clk = ~clk;

    // Run limit from the number of strobes and power cycles
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles while in phase %s", cycle_cnt, phase);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------
    task automatic strobe(
        input logic       e,
        input cred_addr_t ea,
        input logic       d,
        input cred_addr_t da
    );
        @(posedge clk);
        enq_v    <= e;
        enq_addr <= ea;
        deq_v    <= d;
        deq_addr <= da;
    endtask

    task automatic wait_ready();
        @(posedge clk);
        while (!ready) @(posedge clk);
    endtask

    // Every strobe sent so far has been reported or dropped
    task automatic wait_drained();
        strobe(1'b0, '0, 1'b0, '0);
        repeat (2) @(posedge clk);
        while (!balanced) @(posedge clk);
    endtask

    task automatic expect_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            tb_errs = tb_errs + 1;
        end
    endtask

    // ------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------
    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        enq_v           = 1'b0;
        enq_addr        = '0;
        deq_v           = 1'b0;
        deq_addr        = '0;
        pwr_enable_b_in = 1'b0;
        pgcb_isol_en    = 1'b0;
        tb_errs         = 0;
        cycle_cnt       = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        phase = "clear after reset";
        wait_ready();
        strobe(1'b1, 5'd3, 1'b1, 5'd5);
        wait_drained();

        phase = "random traffic";
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            ra  = cred_addr_t'({$random(seed)} % cred_depth);
            rb  = cred_addr_t'({$random(seed)} % cred_depth);
            strobe(rnd[0], ra, rnd[1], rb);
        end
        wait_drained();

        // Both clients hit one address so the write stage forwards
        phase = "forwarding";
        for (int i = 0; i < N_FWD; i++) begin
            strobe(i % 2 == 0, 5'd9, i % 2 == 0, 5'd9);
        end
        wait_drained();

        // Strobes while unpowered fill the queues and then overflow
        phase = "power cycle";
        base_a = enq_drops;
        base_b = deq_drops;
        @(posedge clk);
        pwr_enable_b_in <= 1'b1;
        @(posedge clk);
        while (ready) @(posedge clk);
        for (int i = 0; i < N_OFF_DEQ; i++) begin
            strobe(i < N_OFF_ENQ, 5'd1, 1'b1, 5'd2);
        end
        strobe(1'b0, '0, 1'b0, '0);
        repeat (4) @(posedge clk);
        pwr_enable_b_in <= 1'b0;
        wait_ready();
        wait_drained();
        expect_count("enq_ovf pulses", enq_drops - base_a, N_OFF_ENQ - cred_fifo_depth);
        expect_count("deq_ovf pulses", deq_drops - base_b, N_OFF_DEQ - cred_fifo_depth);

        phase = "saturation";
        base_a = sat_cnt;
        for (int i = 0; i < N_SAT; i++) strobe(1'b1, 5'd7, 1'b0, '0);
        wait_drained();
        expect_count("saturated updates", sat_cnt - base_a, N_SAT - FULL);

        phase = "floor";
        base_b = unf_cnt;
        for (int i = 0; i < N_SAT; i++) strobe(1'b0, '0, 1'b1, 5'd7);
        wait_drained();
        expect_count("underflow updates", unf_cnt - base_b, N_SAT - FULL);

        $display("Checker errors: %0d, testbench errors: %0d", chk_errs, tb_errs);
        if (chk_errs + tb_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cred_ledger_checker.sv */
// ----------------------------------------------------------
// Checker of the credit ledger. Keeps its own ledger model,
// compares every reported update and tallies strobes.
// ----------------------------------------------------------
`default_nettype none

module cred_ledger_checker (
     input  logic                   clk
    ,input  logic                   rst
    ,input  logic                   enq_v
    ,input  logic                   deq_v
    ,input  logic                   pwr_enable_b_in
    ,input  logic                   pwr_enable_b_out
    ,input  logic                   ready
    ,input  logic                   upd_v
    ,input  cred_op_pkg::cred_upd_t upd
    ,input  logic                   enq_ovf
    ,input  logic                   deq_ovf
    ,output int                     err_cnt
    ,output int                     enq_drops
    ,output int                     deq_drops
    ,output int                     sat_cnt
    ,output int                     unf_cnt
    ,output logic                   balanced
);

    import cred_cfg_pkg::*;
    import cred_op_pkg::*;

    // Expected outcome of one update
    typedef struct packed {
        cred_cnt_t cnt;
        logic      sat;
        logic      unf;
    } ref_res_t;

    cred_cnt_t ledger [cred_depth];
    ref_res_t  exp_res;
    int        enq_sent;
    int        deq_sent;
    int        enq_upd;
    int        deq_upd;

    // Two samples of pwr_enable_b_in. The older one, d2, is the
    // expected pwr_enable_b_out
    logic      pwr_d1;
    logic      pwr_d2;
    int        hist_cnt;

    // Every strobe ends either as an update or as an overflow pulse
    assign balanced = (enq_upd + enq_drops == enq_sent) && (deq_upd + deq_drops == deq_sent);

    // ------------------------------------------------------
    // Reference ledger rule
    // ------------------------------------------------------
    function automatic ref_res_t ledger_step(input cred_cnt_t old, input cred_client_e client);
        ref_res_t  res;
        cred_cnt_t full_scale;
        full_scale = cred_cnt_t'((1 << cred_width) - 1);
        res        = '0;
        res.cnt    = old;
        if (client == client_enq) begin
            // An increment at full scale holds the count
            if (old == full_scale) begin
                res.sat = 1'b1;
            end else begin
                res.cnt = old + 1'b1;
            end
        end else begin
            // A decrement at zero holds the count
            if (old == '0) begin
                res.unf = 1'b1;
            end else begin
                res.cnt = old - 1'b1;
            end
        end
        return res;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
        err_cnt = err_cnt + 1;
    endtask

    task automatic failure(input string what);
        $display("Failure at time %0t: %s", $time, what);
        err_cnt = err_cnt + 1;
    endtask

    // ------------------------------------------------------
    // Comparing process
    // ------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            enq_sent  <= 0;
            deq_sent  <= 0;
            enq_upd   <= 0;
            deq_upd   <= 0;
            enq_drops <= 0;
            deq_drops <= 0;
            sat_cnt   <= 0;
            unf_cnt   <= 0;
            hist_cnt  <= 0;
        end else begin
            if (enq_v) enq_sent <= enq_sent + 1;
            if (deq_v) deq_sent <= deq_sent + 1;
            if (enq_ovf) enq_drops <= enq_drops + 1;
            if (deq_ovf) deq_drops <= deq_drops + 1;

            // The power-enable chain delays its input by two cycles
            pwr_d1 <= pwr_enable_b_in;
            pwr_d2 <= pwr_d1;
            if (hist_cnt < 2) begin
                hist_cnt <= hist_cnt + 1;
            end else begin
                if (pwr_enable_b_out !== pwr_d2) begin
                    mismatch("pwr_enable_b_out", pwr_enable_b_out, pwr_d2);
                end
                // An unpowered array serves no request
                if (pwr_d2 && (ready !== 1'b0)) begin
                    mismatch("ready", ready, 1'b0);
                end
                if (pwr_d2 && (upd_v !== 1'b0)) begin
                    failure("update reported while the array is powered down");
                end
            end

            if (upd_v) begin
                if (!ready) failure("update reported while the ledger is not ready");
                if (int'(upd.addr) >= cred_depth) begin
                    failure("update reported for an address outside the ledger");
                end else begin
                    exp_res = ledger_step(ledger[upd.addr], upd.client);
                    if (upd.cnt !== exp_res.cnt) mismatch("upd.cnt", upd.cnt, exp_res.cnt);
                    if (upd.sat !== exp_res.sat) mismatch("upd.sat", upd.sat, exp_res.sat);
                    if (upd.unf !== exp_res.unf) mismatch("upd.unf", upd.unf, exp_res.unf);
                    ledger[upd.addr] <= exp_res.cnt;
                    if (upd.client == client_enq) enq_upd <= enq_upd + 1;
                    else deq_upd <= deq_upd + 1;
                    if (upd.sat) sat_cnt <= sat_cnt + 1;
                    if (upd.unf) unf_cnt <= unf_cnt + 1;
                end
            end
        end

        // Power down loses the array and the sweep after power-up leaves zeros
        if (rst || (pwr_d2 === 1'b1)) begin
            for (int i = 0; i < cred_depth; i++) begin
                ledger[i] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cred_ledger_top.sv */
// ----------------------------------------------------------
// Credit ledger top level. Two client queues share one
// power-gated counter array through an arbiter and a pipeline.
// ----------------------------------------------------------
`default_nettype none

module cred_ledger_top #(
     parameter int DEPTH      = cred_cfg_pkg::cred_depth
    ,parameter int FIFO_DEPTH = cred_cfg_pkg::cred_fifo_depth
) (
     input  logic                     clk
    ,input  logic                     rst

    // Client strobes
    ,input  logic                     enq_v
    ,input  cred_cfg_pkg::cred_addr_t enq_addr
    ,input  logic                     deq_v
    ,input  cred_cfg_pkg::cred_addr_t deq_addr

    // Power interface
    ,input  logic                     pwr_enable_b_in
    ,input  logic                     pgcb_isol_en
    ,output logic                     pwr_enable_b_out

    // Results and status
    ,output logic                     upd_v
    ,output cred_op_pkg::cred_upd_t   upd
    ,output logic                     enq_ovf
    ,output logic                     deq_ovf
    ,output logic                     ready
);

    import cred_op_pkg::*;

    // Queue heads and pops
    cred_req_t               enq_head;
    cred_req_t               deq_head;
    logic                    enq_ne;
    logic                    deq_ne;
    logic                    enq_pop;
    logic                    deq_pop;

    // Grant into the pipeline
    logic                    gnt_v;
    cred_req_t               gnt;
    logic                    accept;

    // Array ports
    logic                    re;
    logic                    we;
    cred_cfg_pkg::cred_addr_t raddr;
    cred_cfg_pkg::cred_addr_t waddr;
    cred_cfg_pkg::cred_cnt_t  wdata;
    cred_cfg_pkg::cred_cnt_t  rdata;
    logic                    rf_ready;

    // ------------------------------------------------------
    // Client queues
    // ------------------------------------------------------
    cred_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .CLIENT(client_enq)) u_enq_fifo (
         .clk(clk), .rst(rst), .push(enq_v), .push_addr(enq_addr), .pop(enq_pop)
        ,.head(enq_head), .not_empty(enq_ne), .ovf(enq_ovf)
    );

    cred_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .CLIENT(client_deq)) u_deq_fifo (
         .clk(clk), .rst(rst), .push(deq_v), .push_addr(deq_addr), .pop(deq_pop)
        ,.head(deq_head), .not_empty(deq_ne), .ovf(deq_ovf)
    );

    // ------------------------------------------------------
    // Arbiter, pipeline and array
    // ------------------------------------------------------
    cred_arb u_arb (
         .clk(clk), .rst(rst), .enq_head(enq_head), .deq_head(deq_head)
        ,.enq_ne(enq_ne), .deq_ne(deq_ne), .accept(accept)
        ,.enq_pop(enq_pop), .deq_pop(deq_pop), .gnt_v(gnt_v), .gnt(gnt)
    );

    cred_rmw_pipe #(.DEPTH(DEPTH)) u_pipe (
         .clk(clk), .rst(rst), .gnt_v(gnt_v), .gnt(gnt), .rf_ready(rf_ready)
        ,.accept(accept), .ready(ready), .re(re), .we(we), .raddr(raddr)
        ,.waddr(waddr), .wdata(wdata), .rdata(rdata), .upd_v(upd_v), .upd(upd)
    );

    cred_rf_pg #(.DEPTH(DEPTH)) u_rf (
         .clk(clk), .rst(rst), .re(re), .we(we), .raddr(raddr), .waddr(waddr)
        ,.wdata(wdata), .rdata(rdata), .pgcb_isol_en(pgcb_isol_en)
        ,.pwr_enable_b_in(pwr_enable_b_in), .pwr_enable_b_out(pwr_enable_b_out)
        ,.rf_ready(rf_ready)
    );

endmodule

`default_nettype wire

/* rtl/cred_rmw_pipe.sv */
// ----------------------------------------------------------
// Read-modify-write pipeline of the credit ledger.
// Clears the array after every power-up, then applies one
// saturating increment or decrement per granted request.
// ----------------------------------------------------------
`default_nettype none

module cred_rmw_pipe #(
     parameter int DEPTH = cred_cfg_pkg::cred_depth
) (
     input  logic                     clk
    ,input  logic                     rst
    ,input  logic                     gnt_v
    ,input  cred_op_pkg::cred_req_t   gnt
    ,input  logic                     rf_ready
    ,output logic                     accept
    ,output logic                     ready
    ,output logic                     re
    ,output logic                     we
    ,output cred_cfg_pkg::cred_addr_t raddr
    ,output cred_cfg_pkg::cred_addr_t waddr
    ,output cred_cfg_pkg::cred_cnt_t  wdata
    ,input  cred_cfg_pkg::cred_cnt_t  rdata
    ,output logic                     upd_v
    ,output cred_op_pkg::cred_upd_t   upd
);

    import cred_cfg_pkg::*;
    import cred_op_pkg::*;

    localparam cred_cnt_t  CNT_MAX   = '1;
    localparam cred_addr_t LAST_ADDR = cred_addr_t'(DEPTH - 1);

    logic       ready_q;
    cred_addr_t clr_addr;
    logic       sweep_on;

    // Write stage registers
    logic       s1_v;
    cred_req_t  s1_req;
    logic       s1_fwd;
    cred_cnt_t  s1_fwd_cnt;

    cred_cnt_t  old_cnt;
    cred_cnt_t  new_cnt;
    logic       sat;
    logic       unf;
    logic       wr_op;
    logic       fwd_hit;

    // ------------------------------------------------------
    // Clear sweep after each rise of rf_ready
    // ------------------------------------------------------

    // Losing the array drops ready in the same cycle
    assign ready    = ready_q & rf_ready;
    assign accept   = ready;
    assign sweep_on = rf_ready & ~ready_q;

    always_ff @(posedge clk) begin
        if (rst || !rf_ready) begin
            ready_q  <= 1'b0;
            clr_addr <= '0;
        end else if (!ready_q) begin
            // Ready follows the cycle of the last clearing write
            if (clr_addr == LAST_ADDR) begin
                ready_q <= 1'b1;
            end
            clr_addr <= (clr_addr == LAST_ADDR) ? '0 : clr_addr + 1'b1;
        end
    end

    // ------------------------------------------------------
    // Read stage
    // ------------------------------------------------------
    assign re    = gnt_v & ready;
    assign raddr = gnt.addr;

    // Write stage updates the word that is read now, so its result is forwarded
    assign wr_op   = s1_v & ready;
    assign fwd_hit = re & wr_op & (s1_req.addr == gnt.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_v   <= 1'b0;
            s1_fwd <= 1'b0;
        end else begin
            s1_v   <= re;
            s1_fwd <= fwd_hit;
        end
    end

    always_ff @(posedge clk) begin
        s1_req     <= gnt;
        s1_fwd_cnt <= new_cnt;
    end

    // ------------------------------------------------------
    // Write stage with saturation
    // ------------------------------------------------------
    assign old_cnt = s1_fwd ? s1_fwd_cnt : rdata;

    always_comb begin
        sat     = 1'b0;
        unf     = 1'b0;
        new_cnt = old_cnt;
        if (s1_req.client == client_enq) begin
            sat = (old_cnt == CNT_MAX);
            if (!sat) begin
                new_cnt = old_cnt + 1'b1;
            end
        end else begin
            unf = (old_cnt == '0);
            if (!unf) begin
                new_cnt = old_cnt - 1'b1;
            end
        end
    end

    // The sweep owns the write port until ready rises
    assign we    = sweep_on | wr_op;
    assign waddr = sweep_on ? clr_addr : s1_req.addr;
    assign wdata = sweep_on ? '0 : new_cnt;

    assign upd_v = wr_op;
    assign upd   = '{addr: s1_req.addr, client: s1_req.client, cnt: new_cnt, sat: sat, unf: unf};

endmodule

`default_nettype wire

/* rtl/cred_arb.sv */
// ----------------------------------------------------------
// Round-robin arbiter between the enq and deq client queues.
// Grants one head per cycle while the pipeline accepts.
// ----------------------------------------------------------
`default_nettype none

module cred_arb (
     input  logic                   clk
    ,input  logic                   rst
    ,input  cred_op_pkg::cred_req_t enq_head
    ,input  cred_op_pkg::cred_req_t deq_head
    ,input  logic                   enq_ne
    ,input  logic                   deq_ne
    ,input  logic                   accept
    ,output logic                   enq_pop
    ,output logic                   deq_pop
    ,output logic                   gnt_v
    ,output cred_op_pkg::cred_req_t gnt
);

    import cred_op_pkg::*;

    // Client that won the last grant
    cred_client_e last_win;

    // High when the deq queue wins this cycle
    logic         pick_deq;

    // ------------------------------------------------------
    // Winner selection, combinational from the heads
    // ------------------------------------------------------

    // With both queues waiting, deq wins only if enq had the last grant.
    // With one queue waiting, that queue wins
    assign pick_deq = deq_ne & (~enq_ne | (last_win == client_enq));

    assign gnt_v   = accept & (enq_ne | deq_ne);
    assign gnt     = pick_deq ? deq_head : enq_head;
    assign enq_pop = gnt_v & ~pick_deq;
    assign deq_pop = gnt_v & pick_deq;

    // Round-robin state, starts as if deq had won so enq goes first
    always_ff @(posedge clk) begin
        if (rst) begin
            last_win <= client_deq;
        end else if (gnt_v) begin
            last_win <= pick_deq ? client_deq : client_enq;
        end
    end

endmodule

`default_nettype wire

/* rtl/cred_req_fifo.sv */
// ----------------------------------------------------------
// Pending queue of one ledger client.
// Strobes become held requests tagged with the client id;
// a strobe that finds the queue full is dropped and flagged.
// ----------------------------------------------------------
`default_nettype none

module cred_req_fifo #(
     parameter int                        FIFO_DEPTH = cred_cfg_pkg::cred_fifo_depth
    ,parameter cred_op_pkg::cred_client_e CLIENT     = cred_op_pkg::client_enq
) (
     input  logic                     clk
    ,input  logic                     rst
    ,input  logic                     push
    ,input  cred_cfg_pkg::cred_addr_t push_addr
    ,input  logic                     pop
    ,output cred_op_pkg::cred_req_t   head
    ,output logic                     not_empty
    ,output logic                     ovf
);

    import cred_op_pkg::*;

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    // Entry storage with one request per slot
    cred_req_t       q [FIFO_DEPTH];
    logic [PW-1:0]   rd_ptr;
    logic [PW-1:0]   wr_ptr;
    logic [CW-1:0]   count;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == CW'(FIFO_DEPTH));

    // A pop in the same cycle frees the slot that a push into a full queue needs
    assign do_pop  = pop & not_empty;
    assign do_push = push & (~full | do_pop);

    assign head = q[rd_ptr];

    // ------------------------------------------------------
    // Pointers, count and overflow flag
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count moves only when exactly one side is active
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // Dropped strobe is reported one cycle later
            ovf <= push & ~do_push;
        end
    end

    // Entry write tagged with this queue's client
    always_ff @(posedge clk) begin
        if (do_push) begin
            q[wr_ptr] <= '{addr: push_addr, client: CLIENT};
        end
    end

endmodule

`default_nettype wire

/* rtl/cred_rf_pg.sv */
// ----------------------------------------------------------
// Power-gated two-port counter array with a registered read.
// rf_ready tells the pipeline when the contents can be used.
// ----------------------------------------------------------
`default_nettype none

module cred_rf_pg #(
     parameter int DEPTH = cred_cfg_pkg::cred_depth
) (
     input  logic                     clk
    ,input  logic                     rst

    ,input  logic                     re
    ,input  logic                     we
    ,input  cred_cfg_pkg::cred_addr_t raddr
    ,input  cred_cfg_pkg::cred_addr_t waddr
    ,input  cred_cfg_pkg::cred_cnt_t  wdata
    ,output cred_cfg_pkg::cred_cnt_t  rdata

    // Power interface
    ,input  logic                     pgcb_isol_en
    ,input  logic                     pwr_enable_b_in
    ,output logic                     pwr_enable_b_out
    ,output logic                     rf_ready
);

    import cred_cfg_pkg::*;

    // Storage, one word per counter
    cred_cnt_t  mem [DEPTH];

    // Registered read data before output gating
    cred_cnt_t  rdata_q;

    // Reset synchronizer, both stages set while rst is high
    logic [1:0] rst_sync;

    // Power-enable chain, stage 1 drives pwr_enable_b_out
    logic [1:0] pwr_q;

    // ------------------------------------------------------
    // Reset synchronizer and power-enable chain
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rst_sync <= 2'b11;
            // The array is treated as unpowered while in reset
            pwr_q    <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], 1'b0};
            pwr_q    <= {pwr_q[0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pwr_q[1];

    // The array is usable only out of reset, powered and not isolated
    assign rf_ready = ~rst_sync[1] & ~pwr_enable_b_out & ~pgcb_isol_en;

    // ------------------------------------------------------
    // Array write port
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pwr_enable_b_out) begin
            // Power is gone, so the contents are lost. Poison every word
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 'x;
            end
        end else if (we && rf_ready && (int'(waddr) < DEPTH)) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------
    // Array read port, one cycle of latency
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (re && rf_ready) begin
            // Out of range addresses read back as zero
            rdata_q <= (int'(raddr) < DEPTH) ? mem[raddr] : '0;
        end
    end

    // Isolation, power down and reset all clamp the read data to zero
    assign rdata = rf_ready ? rdata_q : '0;

endmodule

`default_nettype wire

/* rtl/cred_op_pkg.sv */
// ----------------------------------------------------------
// Request, grant and update formats of the credit ledger.
// Shared by the client queues, the arbiter and the pipeline.
// ----------------------------------------------------------
`default_nettype none

package cred_op_pkg;

    // Client encoding. The client also selects the operation
    // enq adds one, deq subtracts one
    typedef enum logic [0:0] {
        client_enq = 1'b0,
        client_deq = 1'b1
    } cred_client_e;

    // ------------------------------------------------------
    // One pending request, also used as the grant (6 bits)
    // ------------------------------------------------------
    typedef struct packed {
        cred_cfg_pkg::cred_addr_t addr;
        cred_client_e             client;
    } cred_req_t;

    // ------------------------------------------------------
    // Report of one finished update (17 bits)
    // ------------------------------------------------------
    typedef struct packed {
        cred_cfg_pkg::cred_addr_t addr;
        cred_client_e             client;
        // Count after the update has been applied
        cred_cfg_pkg::cred_cnt_t  cnt;
        // Increment seen at full scale, count held
        logic                     sat;
        // Decrement seen at zero, count held
        logic                     unf;
    } cred_upd_t;

endpackage

`default_nettype wire

/* rtl/cred_cfg_pkg.sv */
// ----------------------------------------------------------
// Sizes and default values of the credit ledger.
// The top level takes its parameter defaults from here.
// ----------------------------------------------------------
`default_nettype none

package cred_cfg_pkg;

    // ------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------

    // Number of credit counters held in the register file
    localparam int cred_depth = 24;

    // Counter width. A counter saturates at 2**cred_width - 1
    localparam int cred_width = 9;

    // Enough address bits to reach every counter
    localparam int cred_addr_width = 5;

    // Default number of strobes each client can hold while the ledger is busy
    localparam int cred_fifo_depth = 4;

    // ------------------------------------------------------
    // Basic types
    // ------------------------------------------------------
    typedef logic [cred_addr_width-1:0] cred_addr_t;
    typedef logic [cred_width-1:0]      cred_cnt_t;

endpackage

`default_nettype wire
